/* Makefile */
# Verilator simulation of the PS/2 host subsystem

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check sim.log"
	@echo "make clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ps2_support \
		-Mdir obj_dir -f verilog.f
	./obj_dir/Vtb_ps2_support > sim.log 2>&1; cat sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* common/ps2_byte_if.sv */
// One received PS/2 byte per transfer; the source holds valid, data and err until ready
`timescale 1ns/1ps

interface ps2_byte_if;

   logic       valid;
   logic       ready;
   logic [7:0] data;
   // Bad start, parity or stop bit
   logic       err;

   // Frame receiver side
   modport source (
      output valid,
      output data,
      output err,
      input  ready
   );

   // Decoder or controller side
   modport sink (
      input  valid,
      input  data,
      input  err,
      output ready
   );

endinterface

/* common/ps2_pkg.sv */
// Timing constants assume a 50 MHz clk; scan code set 2 and plain 3-byte mouse packets only
package ps2_pkg;

   ////////////////////////////////////////
   // Timing, in clk cycles

   // Equal samples needed before the PS/2 clock counts as changed
   localparam int FILTER_LEN = 8;
   // Host clock-low pulse before request-to-send, 100 us
   localparam int INHIBIT_CYCLES = 5000;
   // Pause before the first command and between retries
   localparam int RETRY_CYCLES = 2000;
   // Wait for the acknowledge byte
   localparam int ACK_TIMEOUT_CYCLES = 200000;
   // Idle time that drops a partial frame, 1 ms
   localparam int RX_IDLE_CYCLES = 50000;

   ////////////////////////////////////////
   // Protocol bytes

   localparam logic [7:0] CMD_ENABLE_REPORTING = 8'hF4;
   localparam logic [7:0] BYTE_ACK = 8'hFA;
   localparam logic [7:0] BYTE_RESEND = 8'hFE;
   localparam logic [7:0] PREFIX_EXT = 8'hE0;
   localparam logic [7:0] PREFIX_BREAK = 8'hF0;

   // Absolute mouse position
   localparam int POS_W = 12;
   localparam int POS_MAX = (1 << POS_W) - 1;

   // Key event as seen at kb_data
   typedef struct packed {
      logic       is_break;
      logic       is_ext;
      logic [5:0] seq;
      logic [7:0] code;
   } kb_event_t;

   // First byte of a stream packet
   typedef struct packed {
      logic y_ovf;
      logic x_ovf;
      logic y_sign;
      logic x_sign;
      logic always_one;
      logic middle;
      logic right;
      logic left;
   } mouse_status_t;

endpackage

/* design/ps2_rx.sv */
// Device-to-host frames only; a frame that completes while a byte is still held is dropped
`timescale 1ns/1ps

module ps2_rx (
   input  logic       clk,
   input  logic       reset,
   input  logic       enable,
   input  logic       ps2_clk,
   input  logic       ps2_data,
   ps2_byte_if.source out
);

   logic [1:0] clk_sync;
   logic [1:0] data_sync;
   logic [$clog2(ps2_pkg::FILTER_LEN)-1:0] filt_cnt;
   logic clk_filt;
   logic fall;
   logic [10:0] shreg;
   logic [3:0] bit_cnt;
   logic [$clog2(ps2_pkg::RX_IDLE_CYCLES)-1:0] idle_cnt;
   logic frame_done;
   logic frame_err;
   logic load;

   ////////////////////////////////////////
   // Clock filter

   always_ff @(posedge clk) begin
      if (reset) begin
         clk_sync <= 2'b11;
         data_sync <= 2'b11;
         filt_cnt <= '0;
         clk_filt <= 1'b1;
         fall <= 1'b0;
      end else begin
         clk_sync <= {clk_sync[0], ps2_clk};
         data_sync <= {data_sync[0], ps2_data};
         fall <= 1'b0;
         if (clk_sync[1] == clk_filt) begin
            filt_cnt <= '0;
         end else if (filt_cnt == ps2_pkg::FILTER_LEN - 1) begin
            filt_cnt <= '0;
            clk_filt <= clk_sync[1];
            // Old level high means this is a falling edge
            fall <= clk_filt;
         end else begin
            filt_cnt <= filt_cnt + 1'b1;
         end
      end
   end

   ////////////////////////////////////////
   // Frame assembly

   always_ff @(posedge clk) begin
      if (reset) begin
         bit_cnt <= '0;
         idle_cnt <= '0;
         frame_done <= 1'b0;
      end else begin
         frame_done <= 1'b0;
         if (!enable) begin
            bit_cnt <= '0;
            idle_cnt <= '0;
         end else if (fall) begin
            idle_cnt <= '0;
            if (bit_cnt == 4'd10) begin
               bit_cnt <= '0;
               frame_done <= 1'b1;
            end else begin
               bit_cnt <= bit_cnt + 1'b1;
            end
         end else if (bit_cnt != 4'd0) begin
            // Watchdog for a frame the device abandoned
            if (idle_cnt == ps2_pkg::RX_IDLE_CYCLES - 1) begin
               bit_cnt <= '0;
               idle_cnt <= '0;
            end else begin
               idle_cnt <= idle_cnt + 1'b1;
            end
         end
      end
   end

   // LSB first: start in [0], data in [8:1], parity in [9], stop in [10]
   always_ff @(posedge clk) begin
      if (fall) begin
         shreg <= {data_sync[1], shreg[10:1]};
      end
   end

   // Odd parity over data and parity bit
   assign frame_err = shreg[0] | ~(^shreg[9:1]) | ~shreg[10];
   assign load = frame_done && (!out.valid || out.ready);

   ////////////////////////////////////////
   // Byte output

   always_ff @(posedge clk) begin
      if (reset) begin
         out.valid <= 1'b0;
      end else if (load) begin
         out.valid <= 1'b1;
      end else if (out.ready) begin
         out.valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         out.data <= shreg[8:1];
         out.err <= frame_err;
      end
   end

   // A held byte stays put until the consumer takes it
   assert property (@(posedge clk) disable iff (reset)
      out.valid && !out.ready |=> out.valid && $stable(out.data) && $stable(out.err));

endmodule

/* design/ps2_support.sv */
// Line outputs are open-collector levels for an external pad; no back-pressure on the strobes
`timescale 1ns/1ps

module ps2_support (
   input  logic                      clk,
   input  logic                      reset,

   input  logic                      kb_ps2_clk_in,
   input  logic                      kb_ps2_data_in,
   output logic                      kb_ready,
   output logic [15:0]               kb_data,

   input  logic                      ms_ps2_clk_in,
   input  logic                      ms_ps2_data_in,
   output logic                      ms_ready,
   output logic [ps2_pkg::POS_W-1:0] ms_x,
   output logic [ps2_pkg::POS_W-1:0] ms_y,
   output logic [2:0]                ms_button,
   output logic                      ms_ps2_clk_out,
   output logic                      ms_ps2_data_out,
   output logic                      ms_ps2_dir
);

   ps2_byte_if kb_bytes ();
   ps2_byte_if ms_bytes ();

   logic kb_event_valid;
   ps2_pkg::kb_event_t kb_event;

   logic cmd_valid;
   logic [7:0] cmd_data;
   logic cmd_ready;
   logic tx_busy;
   logic tx_done;
   logic tx_nack;
   logic pkt_valid;
   logic [ps2_pkg::POS_W-1:0] pos_x;
   logic [ps2_pkg::POS_W-1:0] pos_y;
   logic [2:0] buttons;

   ////////////////////////////////////////
   // Keyboard

   ps2_rx kb_rx_i (
      .clk      (clk),
      .reset    (reset),
      .enable   (1'b1),
      .ps2_clk  (kb_ps2_clk_in),
      .ps2_data (kb_ps2_data_in),
      .out      (kb_bytes.source)
   );

   kb_scan_decoder kb_dec_i (
      .clk         (clk),
      .reset       (reset),
      .in          (kb_bytes.sink),
      .event_valid (kb_event_valid),
      .kb_event    (kb_event)
   );

   always_ff @(posedge clk) begin
      if (reset) begin
         kb_ready <= 1'b0;
         kb_data <= '0;
      end else begin
         kb_ready <= kb_event_valid;
         kb_data <= kb_event;
      end
   end

   ////////////////////////////////////////
   // Mouse

   // Receiver is held clear while the host owns the line
   ps2_rx ms_rx_i (
      .clk      (clk),
      .reset    (reset),
      .enable   (!tx_busy),
      .ps2_clk  (ms_ps2_clk_in),
      .ps2_data (ms_ps2_data_in),
      .out      (ms_bytes.source)
   );

   mouse_ctrl ms_ctrl_i (
      .clk       (clk),
      .reset     (reset),
      .in        (ms_bytes.sink),
      .cmd_valid (cmd_valid),
      .cmd_data  (cmd_data),
      .cmd_ready (cmd_ready),
      .done      (tx_done),
      .nack      (tx_nack),
      .pkt_valid (pkt_valid),
      .x         (pos_x),
      .y         (pos_y),
      .buttons   (buttons)
   );

   ps2_tx ms_tx_i (
      .clk          (clk),
      .reset        (reset),
      .cmd_valid    (cmd_valid),
      .cmd_data     (cmd_data),
      .cmd_ready    (cmd_ready),
      .busy         (tx_busy),
      .done         (tx_done),
      .nack         (tx_nack),
      .ps2_clk_in   (ms_ps2_clk_in),
      .ps2_data_in  (ms_ps2_data_in),
      .ps2_clk_out  (ms_ps2_clk_out),
      .ps2_data_out (ms_ps2_data_out),
      .ps2_dir      (ms_ps2_dir)
   );

   always_ff @(posedge clk) begin
      if (reset) begin
         ms_ready <= 1'b0;
         ms_x <= '0;
         ms_y <= '0;
         ms_button <= '0;
      end else begin
         ms_ready <= pkt_valid;
         ms_x <= pos_x;
         ms_y <= pos_y;
         ms_button <= buttons;
      end
   end

endmodule

/* keyboard/kb_scan_decoder.sv */
// Scan code set 2 prefixes E0 and F0 only; the E1 pause sequence comes out as plain codes
`timescale 1ns/1ps

module kb_scan_decoder (
   input  logic               clk,
   input  logic               reset,
   ps2_byte_if.sink           in,
   output logic               event_valid,
   output ps2_pkg::kb_event_t kb_event
);

   logic ext_pend;
   logic brk_pend;
   logic [5:0] seq;
   logic take;
   logic code_byte;

   // The keyboard cannot be stalled
   assign in.ready = 1'b1;
   assign take = in.valid && in.ready;
   assign code_byte = take && !in.err && (in.data != ps2_pkg::PREFIX_EXT) &&
                      (in.data != ps2_pkg::PREFIX_BREAK);

   always_ff @(posedge clk) begin
      if (reset) begin
         ext_pend <= 1'b0;
         brk_pend <= 1'b0;
         seq <= '0;
         event_valid <= 1'b0;
      end else begin
         event_valid <= code_byte;
         if (take) begin
            if (in.err || code_byte) begin
               // A bad frame also forgets any pending prefix
               ext_pend <= 1'b0;
               brk_pend <= 1'b0;
            end else if (in.data == ps2_pkg::PREFIX_EXT) begin
               ext_pend <= 1'b1;
            end else begin
               brk_pend <= 1'b1;
            end
         end
         if (code_byte) begin
            seq <= seq + 1'b1;
         end
      end
   end

   // Sequence count wraps so the host can spot gaps
   always_ff @(posedge clk) begin
      if (code_byte) begin
         kb_event.is_break <= brk_pend;
         kb_event.is_ext <= ext_pend;
         kb_event.seq <= seq + 1'b1;
         kb_event.code <= in.data;
      end
   end

endmodule

/* mouse/mouse_ctrl.sv */
// Sends only enable reporting; expects standard 3-byte packets with no wheel byte
`timescale 1ns/1ps

module mouse_ctrl (
   input  logic                      clk,
   input  logic                      reset,
   ps2_byte_if.sink                  in,
   output logic                      cmd_valid,
   output logic [7:0]                cmd_data,
   input  logic                      cmd_ready,
   input  logic                      done,
   input  logic                      nack,
   output logic                      pkt_valid,
   output logic [ps2_pkg::POS_W-1:0] x,
   output logic [ps2_pkg::POS_W-1:0] y,
   output logic [2:0]                buttons
);

   typedef enum logic [2:0] {S_WAIT, S_SEND, S_XFER, S_ACK, S_STREAM} state_t;

   state_t state;
   logic [$clog2(ps2_pkg::ACK_TIMEOUT_CYCLES)-1:0] timer;
   logic [1:0] byte_idx;
   ps2_pkg::mouse_status_t status;
   logic [7:0] dx;
   logic take;
   logic got_ack;
   logic got_resend;

   // Add a 9-bit signed delta and clamp to the position range
   function automatic logic [ps2_pkg::POS_W-1:0] clamp_axis(
      input logic [ps2_pkg::POS_W-1:0] pos,
      input logic                      sign,
      input logic [7:0]                delta
   );
      logic signed [ps2_pkg::POS_W+1:0] sum;
      sum = $signed({2'b00, pos}) + $signed({{(ps2_pkg::POS_W - 6){sign}}, delta});
      if (sum < 0) begin
         return '0;
      end else if (sum > ps2_pkg::POS_MAX) begin
         return {ps2_pkg::POS_W{1'b1}};
      end
      return sum[ps2_pkg::POS_W-1:0];
   endfunction

   // Bytes are taken only while an answer or a packet is expected
   assign in.ready = (state == S_ACK) || (state == S_STREAM);
   assign take = in.valid && in.ready;
   assign got_ack = !in.err && (in.data == ps2_pkg::BYTE_ACK);
   assign got_resend = !in.err && (in.data == ps2_pkg::BYTE_RESEND);
   assign cmd_valid = (state == S_SEND);
   assign cmd_data = ps2_pkg::CMD_ENABLE_REPORTING;

   ////////////////////////////////////////
   // Command phase

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= S_WAIT;
         timer <= '0;
      end else begin
         case (state)
            S_WAIT: begin
               if (timer == ps2_pkg::RETRY_CYCLES - 1) begin
                  timer <= '0;
                  state <= S_SEND;
               end else begin
                  timer <= timer + 1'b1;
               end
            end
            S_SEND: begin
               if (cmd_ready) begin
                  state <= S_XFER;
               end
            end
            S_XFER: begin
               if (done) begin
                  timer <= '0;
                  state <= nack ? S_WAIT : S_ACK;
               end
            end
            S_ACK: begin
               if (take) begin
                  timer <= '0;
                  if (got_ack) begin
                     state <= S_STREAM;
                  end else if (got_resend) begin
                     // Mouse asked for the byte again
                     state <= S_SEND;
                  end else begin
                     state <= S_WAIT;
                  end
               end else if (timer == ps2_pkg::ACK_TIMEOUT_CYCLES - 1) begin
                  timer <= '0;
                  state <= S_WAIT;
               end else begin
                  timer <= timer + 1'b1;
               end
            end
            S_STREAM: begin
               state <= S_STREAM;
            end
            default: begin
               state <= S_WAIT;
            end
         endcase
      end
   end

   ////////////////////////////////////////
   // Stream packets

   always_ff @(posedge clk) begin
      if (reset) begin
         byte_idx <= '0;
         pkt_valid <= 1'b0;
         x <= '0;
         y <= '0;
         buttons <= '0;
      end else begin
         pkt_valid <= 1'b0;
         if (state == S_STREAM && take) begin
            if (in.err) begin
               byte_idx <= '0;
            end else begin
               case (byte_idx)
                  // Bit 3 is always one in a first byte; otherwise resync
                  2'd0: byte_idx <= in.data[3] ? 2'd1 : 2'd0;
                  2'd1: byte_idx <= 2'd2;
                  default: begin
                     byte_idx <= '0;
                     pkt_valid <= 1'b1;
                     buttons <= {status.left, status.middle, status.right};
                     if (!status.x_ovf) begin
                        x <= clamp_axis(x, status.x_sign, dx);
                     end
                     if (!status.y_ovf) begin
                        y <= clamp_axis(y, status.y_sign, in.data);
                     end
                  end
               endcase
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state == S_STREAM && take && byte_idx == 2'd0) begin
         status <= in.data;
      end
      if (state == S_STREAM && take && byte_idx == 2'd1) begin
         dx <= in.data;
      end
   end

   // Position moves only with a packet strobe
   assert property (@(posedge clk) disable iff (reset)
      ($changed(x) || $changed(y)) |-> pkt_valid);

   // A clamped sum moves by one delta at most, so it never wraps past 4095 or 0
   assert property (@(posedge clk) disable iff (reset)
      pkt_valid |-> (int'(x) - int'($past(x)) <= 256) &&
                    (int'($past(x)) - int'(x) <= 256) &&
                    (int'(y) - int'($past(y)) <= 256) &&
                    (int'($past(y)) - int'(y) <= 256));

   // Once streaming, no command is in flight and the transmitter stays idle
   assert property (@(posedge clk) disable iff (reset)
      (state == S_STREAM) |-> cmd_ready && !done);

endmodule

/* mouse/ps2_tx.sv */
// Host-to-device byte send; outputs are open-collector levels, 1 means released
`timescale 1ns/1ps

module ps2_tx (
   input  logic       clk,
   input  logic       reset,
   input  logic       cmd_valid,
   input  logic [7:0] cmd_data,
   output logic       cmd_ready,
   output logic       busy,
   output logic       done,
   output logic       nack,
   input  logic       ps2_clk_in,
   input  logic       ps2_data_in,
   output logic       ps2_clk_out,
   output logic       ps2_data_out,
   output logic       ps2_dir
);

   typedef enum logic [1:0] {S_IDLE, S_INHIBIT, S_SEND} state_t;

   state_t state;
   logic [1:0] clk_sync;
   logic [1:0] data_sync;
   logic [$clog2(ps2_pkg::FILTER_LEN)-1:0] filt_cnt;
   logic clk_filt;
   logic fall;
   logic [$clog2(ps2_pkg::INHIBIT_CYCLES)-1:0] inh_cnt;
   logic [3:0] bit_cnt;
   logic [9:0] shreg;

   assign cmd_ready = (state == S_IDLE);
   assign busy = (state != S_IDLE);

   ////////////////////////////////////////
   // Device clock filter

   always_ff @(posedge clk) begin
      if (reset) begin
         clk_sync <= 2'b11;
         data_sync <= 2'b11;
         filt_cnt <= '0;
         clk_filt <= 1'b1;
         fall <= 1'b0;
      end else begin
         clk_sync <= {clk_sync[0], ps2_clk_in};
         data_sync <= {data_sync[0], ps2_data_in};
         fall <= 1'b0;
         if (clk_sync[1] == clk_filt) begin
            filt_cnt <= '0;
         end else if (filt_cnt == ps2_pkg::FILTER_LEN - 1) begin
            filt_cnt <= '0;
            clk_filt <= clk_sync[1];
            fall <= clk_filt;
         end else begin
            filt_cnt <= filt_cnt + 1'b1;
         end
      end
   end

   ////////////////////////////////////////
   // Send sequence

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= S_IDLE;
         inh_cnt <= '0;
         bit_cnt <= '0;
         done <= 1'b0;
         nack <= 1'b0;
         ps2_clk_out <= 1'b1;
         ps2_data_out <= 1'b1;
         ps2_dir <= 1'b0;
      end else begin
         done <= 1'b0;
         case (state)
            S_IDLE: begin
               if (cmd_valid) begin
                  inh_cnt <= '0;
                  ps2_dir <= 1'b1;
                  ps2_clk_out <= 1'b0;
                  state <= S_INHIBIT;
               end
            end
            S_INHIBIT: begin
               if (inh_cnt == ps2_pkg::INHIBIT_CYCLES - 1) begin
                  // Request-to-send: data low doubles as the start bit
                  ps2_clk_out <= 1'b1;
                  ps2_data_out <= 1'b0;
                  bit_cnt <= '0;
                  state <= S_SEND;
               end else begin
                  inh_cnt <= inh_cnt + 1'b1;
               end
            end
            S_SEND: begin
               if (fall) begin
                  if (bit_cnt == 4'd10) begin
                     // Device pulls data low to acknowledge
                     nack <= data_sync[1];
                     done <= 1'b1;
                     ps2_dir <= 1'b0;
                     state <= S_IDLE;
                  end else begin
                     ps2_data_out <= shreg[0];
                     bit_cnt <= bit_cnt + 1'b1;
                  end
               end
            end
            default: begin
               state <= S_IDLE;
            end
         endcase
      end
   end

   // Data bits LSB first, then odd parity, then stop
   always_ff @(posedge clk) begin
      if (state == S_IDLE && cmd_valid) begin
         shreg <= {1'b1, ~(^cmd_data), cmd_data};
      end else if (state == S_SEND && fall && bit_cnt != 4'd10) begin
         shreg <= {1'b1, shreg[9:1]};
      end
   end

   // The host only pulls a line low while it owns the bus
   assert property (@(posedge clk) disable iff (reset)
      (!ps2_clk_out || !ps2_data_out) |-> ps2_dir);

endmodule

/* verif/ps2_device_bfm.sv */
// Behavioral PS/2 device, changes lines on falling clk; the caller sets the half bit period
`timescale 1ns/1ps

module ps2_device_bfm #(
   parameter bit MOUSE_MODE = 1'b0
) (
   input  logic clk,
   input  logic host_clk,
   input  logic host_data,
   output logic line_clk,
   output logic line_data
);

   logic dev_clk = 1'b1;
   logic dev_data = 1'b1;
   int   low_run = 0;
   int   last_low = 0;

   // Wired-AND lines, only the mouse host may pull low, X counts as released
   assign line_clk = dev_clk && !(MOUSE_MODE && host_clk === 1'b0);
   assign line_data = dev_data && !(MOUSE_MODE && host_data === 1'b0);

   // Length of the latest host clock-low pulse
   always @(negedge clk) begin
      if (host_clk === 1'b0) begin
         low_run <= low_run + 1;
      end else if (low_run != 0) begin
         last_low <= low_run;
         low_run <= 0;
      end
   end

   task automatic hold(input int cycles);
      repeat (cycles) @(negedge clk);
   endtask

   ////////////////////////////////////////
   // Device to host

   task automatic send_frame(input logic [7:0] value, input logic bad_parity, input int half);
      logic [10:0] frame;
      int i;
      frame = {1'b1, ~(^value) ^ bad_parity, value, 1'b0};
      // Idle gap before the start bit
      hold(2 * half);
      for (i = 0; i < 11; i++) begin
         dev_data = frame[i];
         hold(half);
         dev_clk = 1'b0;
         hold(half);
         dev_clk = 1'b1;
      end
      hold(half / 2);
      dev_data = 1'b1;
   endtask

   ////////////////////////////////////////
   // Host to device

   task automatic receive_command(input int half, output logic [7:0] value,
                                  output logic parity, output logic stop,
                                  output int low_cycles);
      logic [9:0] bits;
      int i;
      @(negedge clk);
      // Request-to-send is clock released with data held low
      while (!(host_clk === 1'b1 && host_data === 1'b0)) begin
         @(negedge clk);
      end
      hold(half);
      low_cycles = last_low;
      for (i = 0; i < 10; i++) begin
         dev_clk = 1'b0;
         hold(half);
         // Sampled on the rising device clock
         bits[i] = line_data;
         dev_clk = 1'b1;
         hold(half);
      end
      // Acknowledge bit
      dev_data = 1'b0;
      hold(half / 2);
      dev_clk = 1'b0;
      hold(half);
      dev_clk = 1'b1;
      hold(half / 2);
      dev_data = 1'b1;
      value = bits[7:0];
      parity = bits[8];
      stop = bits[9];
   endtask

endmodule

/* verif/tb_ps2_support.sv */
// Stops at the first failed check; device timing is 40 cycle half bits plus 0 to 7 of jitter
`timescale 1ns/1ps

module tb_ps2_support;

   localparam int RAND_PKTS = 6;
   localparam int CLAMP_PKTS = 17;
   localparam int KB_FRAMES = 11;
   localparam int MS_FRAMES = 4 + 3 * (RAND_PKTS + 2 * CLAMP_PKTS + 3) + 1;
   // Eleven bits of two half periods plus the idle gap, worst case
   localparam int FRAME_CYCLES = 24 * 48;
   localparam int TIMEOUT_CYCLES = (KB_FRAMES + MS_FRAMES) * FRAME_CYCLES +
      2 * (ps2_pkg::RETRY_CYCLES + ps2_pkg::INHIBIT_CYCLES) + 2000;

   logic clk;
   logic reset;
   logic kb_ps2_clk_in;
   logic kb_ps2_data_in;
   logic kb_ready;
   logic [15:0] kb_data;
   logic ms_ps2_clk_in;
   logic ms_ps2_data_in;
   logic ms_ready;
   logic [ps2_pkg::POS_W-1:0] ms_x;
   logic [ps2_pkg::POS_W-1:0] ms_y;
   logic [2:0] ms_button;
   logic ms_ps2_clk_out;
   logic ms_ps2_data_out;
   logic ms_ps2_dir;

   logic [31:0] lfsr = 32'h9643e6f6;
   logic [5:0] kb_seq = '0;
   logic reporting_on = 1'b0;
   int exp_x = 0;
   int exp_y = 0;
   int cycle_count = 0;
   logic [15:0] kb_want;
   logic [15:0] kb_exp_q[$];
   int x_q[$];
   int y_q[$];
   logic [2:0] btn_q[$];

   ps2_support dut_i (.*);

   ps2_device_bfm #(.MOUSE_MODE(1'b0)) kb_dev (
      .clk       (clk),
      .host_clk  (1'b1),
      .host_data (1'b1),
      .line_clk  (kb_ps2_clk_in),
      .line_data (kb_ps2_data_in)
   );

   ps2_device_bfm #(.MOUSE_MODE(1'b1)) ms_dev (
      .clk       (clk),
      .host_clk  (ms_ps2_clk_out),
      .host_data (ms_ps2_data_out),
      .line_clk  (ms_ps2_clk_in),
      .line_data (ms_ps2_data_in)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   ////////////////////////////////////////
   // Helpers

   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] want);
      assert (got === want)
         else stop_on_error($sformatf("MISMATCH %s expected %h got %h", name, want, got));
   endtask

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic draw_bits(input int n, output logic [31:0] r);
      r = '0;
      repeat (n) begin
         lfsr = lfsr_next(lfsr);
         r = {r[30:0], lfsr[0]};
      end
   endtask

   task automatic frame_half(output int half);
      logic [31:0] r;
      draw_bits(3, r);
      half = 40 + int'(r[2:0]);
   endtask

   function automatic int signed_delta(input logic [8:0] d);
      return d[8] ? int'(d) - 512 : int'(d);
   endfunction

   function automatic int clamp_pos(input int v);
      if (v < 0) begin
         return 0;
      end
      return (v > ps2_pkg::POS_MAX) ? ps2_pkg::POS_MAX : v;
   endfunction

   ////////////////////////////////////////
   // Keyboard

   task automatic expect_key(input logic brk, input logic ext, input logic [7:0] code);
      kb_seq = kb_seq + 1'b1;
      kb_exp_q.push_back({brk, ext, kb_seq, code});
   endtask

   task automatic kb_send(input logic [7:0] value, input logic bad_parity);
      int half;
      frame_half(half);
      kb_dev.send_frame(value, bad_parity, half);
   endtask

   task automatic run_keyboard();
      expect_key(1'b0, 1'b0, 8'h1C);
      kb_send(8'h1C, 1'b0);
      expect_key(1'b1, 1'b0, 8'h1C);
      kb_send(8'hF0, 1'b0);
      kb_send(8'h1C, 1'b0);
      expect_key(1'b0, 1'b1, 8'h75);
      kb_send(8'hE0, 1'b0);
      kb_send(8'h75, 1'b0);
      expect_key(1'b1, 1'b1, 8'h75);
      kb_send(8'hE0, 1'b0);
      kb_send(8'hF0, 1'b0);
      kb_send(8'h75, 1'b0);
      // Stray break prefix, then a parity error that must drop it
      kb_send(8'hF0, 1'b0);
      kb_send(8'h1C, 1'b1);
      expect_key(1'b0, 1'b0, 8'h1C);
      kb_send(8'h1C, 1'b0);
   endtask

   ////////////////////////////////////////
   // Mouse

   task automatic ms_send(input logic [7:0] value);
      int half;
      frame_half(half);
      ms_dev.send_frame(value, 1'b0, half);
   endtask

   task automatic check_command();
      int half;
      int low;
      logic [7:0] value;
      logic parity;
      logic stop;
      logic want_parity;
      frame_half(half);
      ms_dev.receive_command(half, value, parity, stop, low);
      // Data and parity bit together hold an odd number of ones
      want_parity = ($countones(ps2_pkg::CMD_ENABLE_REPORTING) % 2) == 0;
      assert (low >= ps2_pkg::INHIBIT_CYCLES)
         else stop_on_error($sformatf("Clock inhibit lasted only %0d cycles", low));
      check_value("ms command", value, ps2_pkg::CMD_ENABLE_REPORTING);
      check_value("ms command parity", parity, want_parity);
      check_value("ms command stop", stop, 1'b1);
   endtask

   task automatic send_packet(input logic [2:0] btn, input logic [8:0] dx,
                              input logic [8:0] dy, input logic x_ovf, input logic y_ovf);
      logic [7:0] status;
      // Buttons are {left, middle, right}, byte 0 has middle, right, left in bits 2 to 0
      status = {y_ovf, x_ovf, dy[8], dx[8], 1'b1, btn[1], btn[0], btn[2]};
      if (!x_ovf) begin
         exp_x = clamp_pos(exp_x + signed_delta(dx));
      end
      if (!y_ovf) begin
         exp_y = clamp_pos(exp_y + signed_delta(dy));
      end
      x_q.push_back(exp_x);
      y_q.push_back(exp_y);
      btn_q.push_back(btn);
      ms_send(status);
      ms_send(dx[7:0]);
      ms_send(dy[7:0]);
   endtask

   task automatic run_mouse();
      logic [31:0] r;
      logic [2:0] btn;
      logic [8:0] dx;
      int i;
      // First attempt is rejected and must be repeated
      check_command();
      ms_send(ps2_pkg::BYTE_RESEND);
      check_command();
      ms_send(ps2_pkg::BYTE_ACK);
      reporting_on = 1'b1;
      for (i = 0; i < RAND_PKTS; i++) begin
         draw_bits(3, r);
         btn = r[2:0];
         draw_bits(9, r);
         dx = r[8:0];
         draw_bits(9, r);
         send_packet(btn, dx, r[8:0], 1'b0, 1'b0);
      end
      for (i = 0; i < CLAMP_PKTS; i++) begin
         send_packet(3'b000, 9'h100, 9'h100, 1'b0, 1'b0);
      end
      for (i = 0; i < CLAMP_PKTS; i++) begin
         send_packet(3'b111, 9'h0FF, 9'h0FF, 1'b0, 1'b0);
      end
      // Overflowed axis keeps its value
      send_packet(3'b100, 9'h19C, 9'h19C, 1'b1, 1'b0);
      send_packet(3'b010, 9'h1F6, 9'h1CE, 1'b0, 1'b1);
      // Byte with bit 3 clear is skipped
      ms_send(8'h41);
      send_packet(3'b001, 9'h020, 9'h1E0, 1'b0, 1'b0);
   endtask

   ////////////////////////////////////////
   // Output monitors

   always @(negedge clk) begin
      if (!reset && kb_ready) begin
         assert (kb_exp_q.size() != 0)
            else stop_on_error("kb_ready pulsed with no key event pending");
         kb_want = kb_exp_q.pop_front();
         check_value("kb_data", kb_data, kb_want);
      end
      if (!reset && ms_ready) begin
         assert (x_q.size() != 0)
            else stop_on_error("ms_ready pulsed with no mouse packet pending");
         check_value("ms_x", ms_x, x_q.pop_front());
         check_value("ms_y", ms_y, y_q.pop_front());
         check_value("ms_button", ms_button, btn_q.pop_front());
      end
   end

   assert property (@(posedge clk) disable iff (reset)
      (!ms_ps2_clk_out || !ms_ps2_data_out) |-> ms_ps2_dir)
      else stop_on_error("Mouse line pulled low while ms_ps2_dir was clear");

   assert property (@(posedge clk) disable iff (reset)
      reporting_on |-> ms_ps2_clk_out && ms_ps2_data_out && !ms_ps2_dir)
      else stop_on_error("Host sent another command after the mouse acknowledged");

   assert property (@(posedge clk) disable iff (reset) kb_ready |=> !kb_ready)
      else stop_on_error("kb_ready stayed high for more than one cycle");

   assert property (@(posedge clk) disable iff (reset) ms_ready |=> !ms_ready)
      else stop_on_error("ms_ready stayed high for more than one cycle");

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      assert (cycle_count < TIMEOUT_CYCLES)
         else stop_on_error($sformatf("Run did not finish within %0d cycles", TIMEOUT_CYCLES));
   end

   ////////////////////////////////////////
   // Scenario

   initial begin
      reset = 1'b1;
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      check_value("kb_ready", kb_ready, 1'b0);
      check_value("kb_data", kb_data, 16'h0000);
      check_value("ms_ready", ms_ready, 1'b0);
      check_value("ms_x", ms_x, 0);
      check_value("ms_y", ms_y, 0);
      check_value("ms_button", ms_button, 3'b000);
      check_value("ms_ps2_clk_out", ms_ps2_clk_out, 1'b1);
      check_value("ms_ps2_data_out", ms_ps2_data_out, 1'b1);
      check_value("ms_ps2_dir", ms_ps2_dir, 1'b0);
      fork
         run_keyboard();
         run_mouse();
      join
      while (kb_exp_q.size() != 0 || x_q.size() != 0) begin
         @(negedge clk);
      end
      // Quiet tail to catch late strobes
      repeat (200) @(negedge clk);
      $display("All tests passed");
      $finish;
   end

endmodule

/* verilog.f */
common/ps2_pkg.sv
common/ps2_byte_if.sv
design/ps2_rx.sv
keyboard/kb_scan_decoder.sv
mouse/ps2_tx.sv
mouse/mouse_ctrl.sv
design/ps2_support.sv
verif/ps2_device_bfm.sv
verif/tb_ps2_support.sv
